// File: common/lc4_pkg.sv
package lc4_pkg;

   localparam int WORD_W    = 16;
   localparam int REG_SEL_W = 3;
   localparam int NZP_W     = 3;
   localparam int NUM_REGS  = 8;

   localparam logic [WORD_W-1:0] RESET_PC = 16'h8200;
   localparam logic [WORD_W-1:0] NOP_INSN = '0;   // branch with no condition bits

   localparam logic [NZP_W-1:0] NZP_NEG  = 3'b100;
   localparam logic [NZP_W-1:0] NZP_ZERO = 3'b010;
   localparam logic [NZP_W-1:0] NZP_POS  = 3'b001;

   typedef enum logic [3:0] {
      OP_BR    = 4'd0,
      OP_ARITH = 4'd1,
      OP_LOGIC = 4'd5,
      OP_LDR   = 4'd6,
      OP_STR   = 4'd7,
      OP_CONST = 4'd9
   } opcode_t;

   typedef enum logic [1:0] {
      STALL_NONE  = 2'd0,
      STALL_FLUSH = 2'd2,   // squashed by a taken branch or reset
      STALL_LOAD  = 2'd3
   } stall_t;

   // condition code of a result, used in execute and in writeback
   function automatic logic [NZP_W-1:0] nzp_of(input logic [WORD_W-1:0] value);
      return value[WORD_W-1] ? NZP_NEG :
             (value == '0)   ? NZP_ZERO : NZP_POS;
   endfunction

endpackage

// File: decode/lc4_decoder.sv
`timescale 1ns/1ns

module lc4_decoder (
   input  logic [lc4_pkg::WORD_W-1:0]    i_insn,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rs,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rt,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rd,
   output logic                          o_rs_re,
   output logic                          o_rt_re,
   output logic                          o_rf_we,
   output logic                          o_nzp_we,
   output logic                          o_is_load,
   output logic                          o_is_store,
   output logic                          o_is_branch
);

   logic alu_ok;   // register-register or immediate ALU form we support

   always_comb begin
      o_rs        = i_insn[8:6];
      o_rt        = i_insn[2:0];
      o_rd        = i_insn[11:9];
      o_rs_re     = 1'b0;
      o_rt_re     = 1'b0;
      o_rf_we     = 1'b0;
      o_nzp_we    = 1'b0;
      o_is_load   = 1'b0;
      o_is_store  = 1'b0;
      o_is_branch = 1'b0;
      alu_ok      = 1'b0;
      case (lc4_pkg::opcode_t'(i_insn[15:12]))
         lc4_pkg::OP_BR:    o_is_branch = |i_insn[11:9];   // nzp=000 never branches
         lc4_pkg::OP_ARITH: alu_ok = i_insn[5] | ~i_insn[3];   // no mul or div
         lc4_pkg::OP_LOGIC: alu_ok = ~i_insn[5] & (i_insn[4] | ~i_insn[3]);   // and, or, xor
         lc4_pkg::OP_LDR: begin
            o_rs_re   = 1'b1;
            o_rf_we   = 1'b1;
            o_nzp_we  = 1'b1;
            o_is_load = 1'b1;
         end
         lc4_pkg::OP_STR: begin
            o_rt       = i_insn[11:9];   // store data lives in the rd field
            o_rs_re    = 1'b1;
            o_rt_re    = 1'b1;
            o_is_store = 1'b1;
         end
         lc4_pkg::OP_CONST: begin
            o_rf_we  = 1'b1;
            o_nzp_we = 1'b1;
         end
         default: ;
      endcase
      if (alu_ok) begin
         o_rs_re  = 1'b1;
         o_rt_re  = ~i_insn[5];   // immediate form has no rt
         o_rf_we  = 1'b1;
         o_nzp_we = 1'b1;
      end
   end

endmodule

// File: decode/lc4_decode_stage.sv
`timescale 1ns/1ns

module lc4_decode_stage (
   input  logic                          gwe,
   input  logic                          i_reset,
   input  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn,
   input  logic                          i_branch_taken,
   input  logic [lc4_pkg::WORD_W-1:0]    i_branch_target,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rd,
   input  logic                          i_x_rf_we,
   input  logic                          i_x_is_load,
   input  logic                          i_x_nzp_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_cur_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_d_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_d_insn,
   output lc4_pkg::stall_t               o_d_stall,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_d_rs,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_d_rt,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_d_rd,
   output logic                          o_d_rf_we,
   output logic                          o_d_nzp_we,
   output logic                          o_d_is_load,
   output logic                          o_d_is_store,
   output logic                          o_d_is_branch
);

   logic [lc4_pkg::WORD_W-1:0] fd_insn;
   lc4_pkg::stall_t            fd_stall;
   logic rs_re, rt_re, rf_we, nzp_we, is_load, is_store, is_branch;
   logic load_use;
   logic bubble;

   lc4_decoder u_decoder (
      .i_insn      (fd_insn),
      .o_rs        (o_d_rs),
      .o_rt        (o_d_rt),
      .o_rd        (o_d_rd),
      .o_rs_re     (rs_re),
      .o_rt_re     (rt_re),
      .o_rf_we     (rf_we),
      .o_nzp_we    (nzp_we),
      .o_is_load   (is_load),
      .o_is_store  (is_store),
      .o_is_branch (is_branch)
   );

   // load in execute feeds a register or the nzp of the decode-slot insn
   assign load_use = i_x_is_load &
                     ((i_x_rf_we & ((rs_re & (o_d_rs == i_x_rd)) |
                                    (rt_re & (o_d_rt == i_x_rd)))) |
                      (i_x_nzp_we & is_branch));
   assign bubble   = i_branch_taken | load_use;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_cur_pc <= lc4_pkg::RESET_PC;
         fd_insn  <= lc4_pkg::NOP_INSN;
         fd_stall <= lc4_pkg::STALL_FLUSH;
      end else if (i_branch_taken) begin   // wins over a load stall
         o_cur_pc <= i_branch_target;
         fd_insn  <= lc4_pkg::NOP_INSN;
         fd_stall <= lc4_pkg::STALL_FLUSH;
      end else if (!load_use) begin
         o_cur_pc <= o_cur_pc + 1'b1;
         fd_insn  <= i_cur_insn;
         fd_stall <= lc4_pkg::STALL_NONE;
      end
   end

   always_ff @(posedge gwe) begin
      if (!load_use) o_d_pc <= o_cur_pc;
   end

   assign o_d_insn      = bubble ? lc4_pkg::NOP_INSN : fd_insn;
   assign o_d_stall     = i_branch_taken ? lc4_pkg::STALL_FLUSH :
                          load_use       ? lc4_pkg::STALL_LOAD  : fd_stall;
   assign o_d_rf_we     = rf_we & ~bubble;
   assign o_d_nzp_we    = nzp_we & ~bubble;
   assign o_d_is_load   = is_load & ~bubble;
   assign o_d_is_store  = is_store & ~bubble;
   assign o_d_is_branch = is_branch & ~bubble;

endmodule

// File: execute/lc4_alu.sv
`timescale 1ns/1ns

module lc4_alu (
   input  logic [lc4_pkg::WORD_W-1:0] i_insn,
   input  logic [lc4_pkg::WORD_W-1:0] i_pc,
   input  logic [lc4_pkg::WORD_W-1:0] i_rs,
   input  logic [lc4_pkg::WORD_W-1:0] i_rt,
   output logic [lc4_pkg::WORD_W-1:0] o_result
);

   logic [lc4_pkg::WORD_W-1:0] imm5, imm6, imm9;

   assign imm5 = {{(lc4_pkg::WORD_W-5){i_insn[4]}}, i_insn[4:0]};
   assign imm6 = {{(lc4_pkg::WORD_W-6){i_insn[5]}}, i_insn[5:0]};
   assign imm9 = {{(lc4_pkg::WORD_W-9){i_insn[8]}}, i_insn[8:0]};

   always_comb begin
      case (lc4_pkg::opcode_t'(i_insn[15:12]))
         lc4_pkg::OP_BR:    o_result = i_pc + 1'b1 + imm9;   // branch target
         lc4_pkg::OP_ARITH: begin
            if (i_insn[5])      o_result = i_rs + imm5;
            else if (i_insn[4]) o_result = i_rs - i_rt;
            else                o_result = i_rs + i_rt;
         end
         lc4_pkg::OP_LOGIC: begin
            case (i_insn[4:3])
               2'b10:   o_result = i_rs | i_rt;
               2'b11:   o_result = i_rs ^ i_rt;
               default: o_result = i_rs & i_rt;
            endcase
         end
         lc4_pkg::OP_LDR, lc4_pkg::OP_STR: o_result = i_rs + imm6;   // data address
         lc4_pkg::OP_CONST: o_result = imm9;
         default:           o_result = '0;
      endcase
   end

endmodule

// File: execute/lc4_execute_stage.sv
`timescale 1ns/1ns

module lc4_execute_stage (
   input  logic                          gwe,
   input  logic                          i_reset,
   input  logic [lc4_pkg::WORD_W-1:0]    i_d_pc,
   input  logic [lc4_pkg::WORD_W-1:0]    i_d_insn,
   input  lc4_pkg::stall_t               i_d_stall,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rs,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rt,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_d_rd,
   input  logic                          i_d_rf_we,
   input  logic                          i_d_nzp_we,
   input  logic                          i_d_is_load,
   input  logic                          i_d_is_store,
   input  logic                          i_d_is_branch,
   input  logic [lc4_pkg::WORD_W-1:0]    i_rs_data,
   input  logic [lc4_pkg::WORD_W-1:0]    i_rt_data,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_m_rd,
   input  logic                          i_m_rf_we,
   input  logic [lc4_pkg::WORD_W-1:0]    i_m_result,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_w_rd,
   input  logic                          i_w_rf_we,
   input  logic [lc4_pkg::WORD_W-1:0]    i_w_result,
   input  logic                          i_w_load_nzp_valid,
   input  logic [lc4_pkg::NZP_W-1:0]     i_w_load_nzp,
   output logic                          o_branch_taken,
   output logic [lc4_pkg::WORD_W-1:0]    o_branch_target,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_x_rd,
   output logic                          o_x_rf_we,
   output logic                          o_x_is_load,
   output logic                          o_x_nzp_we,
   output logic                          o_x_is_store,
   output logic [lc4_pkg::WORD_W-1:0]    o_x_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_x_insn,
   output lc4_pkg::stall_t               o_x_stall,
   output logic [lc4_pkg::WORD_W-1:0]    o_x_result,
   output logic [lc4_pkg::WORD_W-1:0]    o_x_store_data,
   output logic [lc4_pkg::NZP_W-1:0]     o_x_nzp
);

   logic [lc4_pkg::REG_SEL_W-1:0] x_rs, x_rt;
   logic [lc4_pkg::WORD_W-1:0]    x_rs_data, x_rt_data, rs_fwd;
   logic                          x_is_branch;
   logic [lc4_pkg::NZP_W-1:0]     nzp_reg, cur_nzp;

   // youngest producer first
   function automatic logic [lc4_pkg::WORD_W-1:0] fwd(
      input logic [lc4_pkg::REG_SEL_W-1:0] sel,
      input logic [lc4_pkg::WORD_W-1:0]    rf_val
   );
      if (i_m_rf_we && i_m_rd == sel)      return i_m_result;
      else if (i_w_rf_we && i_w_rd == sel) return i_w_result;
      return rf_val;
   endfunction

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         o_x_insn    <= lc4_pkg::NOP_INSN;
         o_x_stall   <= lc4_pkg::STALL_FLUSH;
         o_x_rf_we   <= 1'b0;
         o_x_nzp_we  <= 1'b0;
         o_x_is_load <= 1'b0;
         o_x_is_store <= 1'b0;
         x_is_branch <= 1'b0;
         nzp_reg     <= lc4_pkg::NZP_ZERO;
      end else begin
         o_x_insn    <= i_d_insn;
         o_x_stall   <= i_d_stall;
         o_x_rf_we   <= i_d_rf_we;
         o_x_nzp_we  <= i_d_nzp_we;
         o_x_is_load <= i_d_is_load;
         o_x_is_store <= i_d_is_store;
         x_is_branch <= i_d_is_branch;
         if (o_x_nzp_we && !o_x_is_load) begin   // younger writer beats the load
            nzp_reg <= o_x_nzp;
         end else if (i_w_load_nzp_valid) begin
            nzp_reg <= i_w_load_nzp;
         end
      end
   end

   always_ff @(posedge gwe) begin
      o_x_pc    <= i_d_pc;
      o_x_rd    <= i_d_rd;
      x_rs      <= i_d_rs;
      x_rt      <= i_d_rt;
      x_rs_data <= i_rs_data;
      x_rt_data <= i_rt_data;
   end

   always_comb begin
      rs_fwd         = fwd(x_rs, x_rs_data);
      o_x_store_data = fwd(x_rt, x_rt_data);
   end

   lc4_alu u_alu (
      .i_insn   (o_x_insn),
      .i_pc     (o_x_pc),
      .i_rs     (rs_fwd),
      .i_rt     (o_x_store_data),
      .o_result (o_x_result)
   );

   assign o_x_nzp         = lc4_pkg::nzp_of(o_x_result);
   assign cur_nzp         = i_w_load_nzp_valid ? i_w_load_nzp : nzp_reg;   // load nzp lands late
   assign o_branch_taken  = x_is_branch & |(o_x_insn[11:9] & cur_nzp);
   assign o_branch_target = o_x_result;

endmodule

// File: verilog/lc4_regfile.sv
`timescale 1ns/1ns

module lc4_regfile (
   input  logic                          gwe,
   input  logic                          i_reset,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rs,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rt,
   output logic [lc4_pkg::WORD_W-1:0]    o_rs_data,
   output logic [lc4_pkg::WORD_W-1:0]    o_rt_data,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_rd,
   input  logic                          i_rd_we,
   input  logic [lc4_pkg::WORD_W-1:0]    i_wdata
);

   logic [lc4_pkg::WORD_W-1:0] regs [lc4_pkg::NUM_REGS];

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         for (int i = 0; i < lc4_pkg::NUM_REGS; i++) regs[i] <= '0;
      end else if (i_rd_we) begin
         regs[i_rd] <= i_wdata;
      end
   end

   // writeback data shows through in the same cycle
   assign o_rs_data = (i_rd_we && i_rd == i_rs) ? i_wdata : regs[i_rs];
   assign o_rt_data = (i_rd_we && i_rd == i_rt) ? i_wdata : regs[i_rt];

endmodule

// File: result/lc4_result_stage.sv
`timescale 1ns/1ns

module lc4_result_stage (
   input  logic                          gwe,
   input  logic                          i_reset,
   input  logic [lc4_pkg::WORD_W-1:0]    i_x_pc,
   input  logic [lc4_pkg::WORD_W-1:0]    i_x_insn,
   input  lc4_pkg::stall_t               i_x_stall,
   input  logic [lc4_pkg::WORD_W-1:0]    i_x_result,
   input  logic [lc4_pkg::WORD_W-1:0]    i_x_store_data,
   input  logic [lc4_pkg::REG_SEL_W-1:0] i_x_rd,
   input  logic                          i_x_rf_we,
   input  logic                          i_x_nzp_we,
   input  logic                          i_x_is_load,
   input  logic                          i_x_is_store,
   input  logic [lc4_pkg::NZP_W-1:0]     i_x_nzp,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dmem_rdata,
   output logic [lc4_pkg::WORD_W-1:0]    o_dmem_addr,
   output logic                          o_dmem_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_dmem_wdata,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_m_rd,
   output logic                          o_m_rf_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_m_result,
   output logic                          o_w_load_nzp_valid,
   output logic [lc4_pkg::NZP_W-1:0]     o_w_load_nzp,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_rf_wsel,
   output logic                          o_rf_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_rf_wdata,
   output lc4_pkg::stall_t               o_wb_stall,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_insn,
   output logic                          o_wb_rf_we,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rf_wsel,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_rf_wdata,
   output logic                          o_wb_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]     o_wb_nzp
);

   logic [lc4_pkg::WORD_W-1:0] m_pc, m_insn, w_result, w_rdata;
   lc4_pkg::stall_t            m_stall;
   logic                       m_nzp_we, m_is_load, w_is_load;
   logic [lc4_pkg::NZP_W-1:0]  m_nzp, w_nzp;

   always_ff @(posedge gwe) begin
      if (i_reset) begin
         m_stall     <= lc4_pkg::STALL_FLUSH;
         o_m_rf_we   <= 1'b0;
         m_nzp_we    <= 1'b0;
         m_is_load   <= 1'b0;
         o_dmem_we   <= 1'b0;
         o_wb_stall  <= lc4_pkg::STALL_FLUSH;
         o_rf_we     <= 1'b0;
         o_wb_nzp_we <= 1'b0;
         w_is_load   <= 1'b0;
      end else begin
         m_stall     <= i_x_stall;
         o_m_rf_we   <= i_x_rf_we;
         m_nzp_we    <= i_x_nzp_we;
         m_is_load   <= i_x_is_load;
         o_dmem_we   <= i_x_is_store;
         o_wb_stall  <= m_stall;
         o_rf_we     <= o_m_rf_we;
         o_wb_nzp_we <= m_nzp_we;
         w_is_load   <= m_is_load;
      end
   end

   always_ff @(posedge gwe) begin
      m_pc         <= i_x_pc;
      m_insn       <= i_x_insn;
      o_m_result   <= i_x_result;
      o_dmem_wdata <= i_x_store_data;   // rt already forwarded in execute
      o_m_rd       <= i_x_rd;
      m_nzp        <= i_x_nzp;
      o_wb_pc      <= m_pc;
      o_wb_insn    <= m_insn;
      w_result     <= o_m_result;
      w_rdata      <= i_dmem_rdata;
      o_rf_wsel    <= o_m_rd;
      w_nzp        <= m_nzp;
   end

   assign o_dmem_addr = o_m_result;

   assign o_rf_wdata   = w_is_load ? w_rdata : w_result;
   assign o_w_load_nzp = lc4_pkg::nzp_of(w_rdata);
   // a younger nzp writer in memory has already updated the register
   assign o_w_load_nzp_valid = w_is_load & ~m_nzp_we;

   assign o_wb_rf_we    = o_rf_we;
   assign o_wb_rf_wsel  = o_rf_wsel;
   assign o_wb_rf_wdata = o_rf_wdata;
   assign o_wb_nzp      = w_is_load ? o_w_load_nzp : w_nzp;

endmodule

// File: verilog/lc4_pipeline.sv
`timescale 1ns/1ns

module lc4_pipeline (
   input  logic                          gwe,
   input  logic                          i_reset,
   output logic [lc4_pkg::WORD_W-1:0]    o_cur_pc,
   input  logic [lc4_pkg::WORD_W-1:0]    i_cur_insn,
   output logic [lc4_pkg::WORD_W-1:0]    o_dmem_addr,
   output logic                          o_dmem_we,
   output logic [lc4_pkg::WORD_W-1:0]    o_dmem_wdata,
   input  logic [lc4_pkg::WORD_W-1:0]    i_dmem_rdata,
   output lc4_pkg::stall_t               o_wb_stall,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_pc,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_insn,
   output logic                          o_wb_rf_we,
   output logic [lc4_pkg::REG_SEL_W-1:0] o_wb_rf_wsel,
   output logic [lc4_pkg::WORD_W-1:0]    o_wb_rf_wdata,
   output logic                          o_wb_nzp_we,
   output logic [lc4_pkg::NZP_W-1:0]     o_wb_nzp
);

   logic [lc4_pkg::WORD_W-1:0]    d_pc, d_insn, rs_data, rt_data, x_branch_target;
   lc4_pkg::stall_t               d_stall, x_stall;
   logic [lc4_pkg::REG_SEL_W-1:0] d_rs, d_rt, d_rd, x_rd, m_rd, rf_wsel;
   logic d_rf_we, d_nzp_we, d_is_load, d_is_store, d_is_branch;
   logic x_branch_taken, x_rf_we, x_is_load, x_nzp_we, x_is_store;
   logic [lc4_pkg::WORD_W-1:0]    x_pc, x_insn, x_result, x_store_data, m_result, rf_wdata;
   logic [lc4_pkg::NZP_W-1:0]     x_nzp, w_load_nzp;
   logic m_rf_we, w_load_nzp_valid, rf_we;

   lc4_decode_stage u_decode_stage (
      .gwe (gwe), .i_reset (i_reset),
      .i_cur_insn (i_cur_insn),
      .i_branch_taken (x_branch_taken), .i_branch_target (x_branch_target),
      .i_x_rd (x_rd), .i_x_rf_we (x_rf_we),
      .i_x_is_load (x_is_load), .i_x_nzp_we (x_nzp_we),
      .o_cur_pc (o_cur_pc), .o_d_pc (d_pc), .o_d_insn (d_insn), .o_d_stall (d_stall),
      .o_d_rs (d_rs), .o_d_rt (d_rt), .o_d_rd (d_rd),
      .o_d_rf_we (d_rf_we), .o_d_nzp_we (d_nzp_we), .o_d_is_load (d_is_load),
      .o_d_is_store (d_is_store), .o_d_is_branch (d_is_branch)
   );

   lc4_regfile u_regfile (
      .gwe (gwe), .i_reset (i_reset),
      .i_rs (d_rs), .i_rt (d_rt), .o_rs_data (rs_data), .o_rt_data (rt_data),
      .i_rd (rf_wsel), .i_rd_we (rf_we), .i_wdata (rf_wdata)
   );

   lc4_execute_stage u_execute_stage (
      .gwe (gwe), .i_reset (i_reset),
      .i_d_pc (d_pc), .i_d_insn (d_insn), .i_d_stall (d_stall),
      .i_d_rs (d_rs), .i_d_rt (d_rt), .i_d_rd (d_rd),
      .i_d_rf_we (d_rf_we), .i_d_nzp_we (d_nzp_we), .i_d_is_load (d_is_load),
      .i_d_is_store (d_is_store), .i_d_is_branch (d_is_branch),
      .i_rs_data (rs_data), .i_rt_data (rt_data),
      .i_m_rd (m_rd), .i_m_rf_we (m_rf_we), .i_m_result (m_result),
      .i_w_rd (rf_wsel), .i_w_rf_we (rf_we), .i_w_result (rf_wdata),
      .i_w_load_nzp_valid (w_load_nzp_valid), .i_w_load_nzp (w_load_nzp),
      .o_branch_taken (x_branch_taken), .o_branch_target (x_branch_target),
      .o_x_rd (x_rd), .o_x_rf_we (x_rf_we), .o_x_is_load (x_is_load),
      .o_x_nzp_we (x_nzp_we), .o_x_is_store (x_is_store),
      .o_x_pc (x_pc), .o_x_insn (x_insn), .o_x_stall (x_stall),
      .o_x_result (x_result), .o_x_store_data (x_store_data), .o_x_nzp (x_nzp)
   );

   lc4_result_stage u_result_stage (
      .gwe (gwe), .i_reset (i_reset),
      .i_x_pc (x_pc), .i_x_insn (x_insn), .i_x_stall (x_stall),
      .i_x_result (x_result), .i_x_store_data (x_store_data), .i_x_rd (x_rd),
      .i_x_rf_we (x_rf_we), .i_x_nzp_we (x_nzp_we), .i_x_is_load (x_is_load),
      .i_x_is_store (x_is_store), .i_x_nzp (x_nzp),
      .i_dmem_rdata (i_dmem_rdata), .o_dmem_addr (o_dmem_addr),
      .o_dmem_we (o_dmem_we), .o_dmem_wdata (o_dmem_wdata),
      .o_m_rd (m_rd), .o_m_rf_we (m_rf_we), .o_m_result (m_result),
      .o_w_load_nzp_valid (w_load_nzp_valid), .o_w_load_nzp (w_load_nzp),
      .o_rf_wsel (rf_wsel), .o_rf_we (rf_we), .o_rf_wdata (rf_wdata),
      .o_wb_stall (o_wb_stall), .o_wb_pc (o_wb_pc), .o_wb_insn (o_wb_insn),
      .o_wb_rf_we (o_wb_rf_we), .o_wb_rf_wsel (o_wb_rf_wsel),
      .o_wb_rf_wdata (o_wb_rf_wdata), .o_wb_nzp_we (o_wb_nzp_we), .o_wb_nzp (o_wb_nzp)
   );

endmodule

// File: sim/lc4_pipeline_chk.sv
`timescale 1ns/1ns

module lc4_pipeline_chk (
   input logic                      gwe,
   input logic                      i_reset,
   input logic                      i_dmem_we,
   input lc4_pkg::stall_t           i_wb_stall,
   input logic                      i_wb_rf_we,
   input logic                      i_wb_nzp_we,
   input logic [lc4_pkg::NZP_W-1:0] i_wb_nzp
);

   // reset clears the store strobe at its edge
   a_no_store_in_reset: assert property (@(posedge gwe) i_reset |=> !i_dmem_we)
      else $error("data memory write enable high during reset");

   a_write_on_retire: assert property (@(posedge gwe) disable iff (i_reset)
      i_wb_rf_we |-> i_wb_stall == lc4_pkg::STALL_NONE)
      else $error("register write on a bubble record");

   a_stall_named: assert property (@(posedge gwe) disable iff (i_reset)
      i_wb_stall inside {lc4_pkg::STALL_NONE, lc4_pkg::STALL_FLUSH, lc4_pkg::STALL_LOAD})
      else $error("trace stall code is not a named value");

   a_nzp_one_hot: assert property (@(posedge gwe) disable iff (i_reset)
      i_wb_nzp_we |-> $onehot(i_wb_nzp))
      else $error("retired nzp is not one-hot");

endmodule

bind lc4_pipeline lc4_pipeline_chk u_chk (
   .gwe         (gwe),
   .i_reset     (i_reset),
   .i_dmem_we   (o_dmem_we),
   .i_wb_stall  (o_wb_stall),
   .i_wb_rf_we  (o_wb_rf_we),
   .i_wb_nzp_we (o_wb_nzp_we),
   .i_wb_nzp    (o_wb_nzp)
);

// File: sim/lc4_pipeline_tb.sv
`timescale 1ns/1ns

module lc4_pipeline_tb;

   localparam int          PROG_LEN     = 200;
   localparam int          RESET_CYCLES = 8;
   localparam logic [15:0] END_PC       = lc4_pkg::RESET_PC + 16'(PROG_LEN);

   logic            gwe;
   logic            i_reset;
   logic [15:0]     i_cur_insn, i_dmem_rdata;
   logic [15:0]     o_cur_pc, o_dmem_addr, o_dmem_wdata, o_wb_pc, o_wb_insn, o_wb_rf_wdata;
   logic            o_dmem_we, o_wb_rf_we, o_wb_nzp_we;
   logic [2:0]      o_wb_rf_wsel, o_wb_nzp;
   lc4_pkg::stall_t o_wb_stall;

   logic [15:0] imem [PROG_LEN];
   logic [15:0] dmem [65536];
   logic [15:0] model_mem [logic [15:0]];   // ISA view of data memory
   logic [15:0] m_regs [8];
   logic [15:0] m_pc;
   logic [2:0]  m_nzp;
   logic [31:0] store_q [$];                // {addr, data} seen on the port
   lc4_pkg::stall_t pend_kind;
   int          pend_count;
   int          retired;
   bit          started;

   lc4_pipeline uut (.*);

   initial begin
      gwe = 1'b0;
      forever #4 gwe = ~gwe;
   end

   function automatic logic [15:0] prog_word(input logic [15:0] pc);
      logic [15:0] idx;
      idx = pc - lc4_pkg::RESET_PC;
      return (idx < PROG_LEN) ? imem[idx] : lc4_pkg::NOP_INSN;
   endfunction

   assign i_cur_insn   = prog_word(o_cur_pc);
   assign i_dmem_rdata = dmem[o_dmem_addr];

   always @(posedge gwe) begin
      if (o_dmem_we === 1'b1) dmem[o_dmem_addr] <= o_dmem_wdata;
   end

   function automatic logic [15:0] random_insn();
      logic [2:0] rd, rs, rt;
      logic [8:0] imm;
      int         kind, sub;
      rd   = 3'($urandom_range(0, 7));
      rs   = 3'($urandom_range(0, 7));
      rt   = 3'($urandom_range(0, 7));
      imm  = 9'($urandom);
      kind = $urandom_range(0, 9);
      sub  = $urandom_range(0, 2);
      case (kind)
         0, 1: return (sub == 0) ? {4'h1, rd, rs, 3'b000, rt} :
                      (sub == 1) ? {4'h1, rd, rs, 3'b010, rt} : {4'h1, rd, rs, 1'b1, imm[4:0]};
         2, 3: return {4'h5, rd, rs, (sub == 0) ? 3'b000 : (sub == 1) ? 3'b010 : 3'b011, rt};
         4:    return {4'h6, rd, rs, imm[5:0]};
         5:    return {4'h7, rd, rs, imm[5:0]};
         6, 7: return {4'h9, rd, imm};
         default: return {4'h0, rd, 6'b0, imm[2:0]};   // short forward hop with nzp mask in rd
      endcase
   endfunction

   function automatic logic [2:0] cond_code(input logic [15:0] value);
      if (value[15]) return lc4_pkg::NZP_NEG;
      if (value == 16'h0) return lc4_pkg::NZP_ZERO;
      return lc4_pkg::NZP_POS;
   endfunction

   // does the next instruction need the load result or its nzp
   function automatic logic load_hazard(input logic [15:0] nxt, input logic [2:0] rd);
      case (lc4_pkg::opcode_t'(nxt[15:12]))
         lc4_pkg::OP_BR:    return nxt[11:9] != 3'b000;
         lc4_pkg::OP_ARITH: return nxt[8:6] == rd || (!nxt[5] && nxt[2:0] == rd);
         lc4_pkg::OP_LOGIC: return nxt[8:6] == rd || nxt[2:0] == rd;
         lc4_pkg::OP_LDR:   return nxt[8:6] == rd;
         lc4_pkg::OP_STR:   return nxt[8:6] == rd || nxt[11:9] == rd;
         default:           return 1'b0;
      endcase
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp)
         abort_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic retire_step;
      logic [15:0] insn, rs_v, rt_v, res, addr, next_pc;
      logic [31:0] st;
      logic        we, taken;
      insn    = prog_word(m_pc);
      rs_v    = m_regs[insn[8:6]];
      rt_v    = m_regs[insn[2:0]];
      res     = '0;
      addr    = rs_v + {{10{insn[5]}}, insn[5:0]};
      we      = 1'b0;
      taken   = 1'b0;
      next_pc = m_pc + 16'd1;
      check_value("o_wb_pc", o_wb_pc, m_pc);
      check_value("o_wb_insn", o_wb_insn, insn);
      case (lc4_pkg::opcode_t'(insn[15:12]))
         lc4_pkg::OP_BR: begin
            taken = |(insn[11:9] & m_nzp);
            if (taken) next_pc = next_pc + {{7{insn[8]}}, insn[8:0]};
         end
         lc4_pkg::OP_ARITH: begin
            we = 1'b1;
            case (insn[5:3])
               3'b000:  res = rs_v + rt_v;
               3'b010:  res = rs_v - rt_v;
               default: res = rs_v + {{11{insn[4]}}, insn[4:0]};   // 1xx adds the immediate
            endcase
         end
         lc4_pkg::OP_LOGIC: begin
            we = 1'b1;
            case (insn[5:3])
               3'b000:  res = rs_v & rt_v;
               3'b010:  res = rs_v | rt_v;
               3'b011:  res = rs_v ^ rt_v;
               default: ;
            endcase
         end
         lc4_pkg::OP_LDR: begin
            we  = 1'b1;
            res = model_mem.exists(addr) ? model_mem[addr] : addr;   // unwritten word holds its address
         end
         lc4_pkg::OP_STR: begin
            if (store_q.size() == 0) begin
               abort_run("a store retired without any data memory write");
            end else begin
               st = store_q.pop_front();
               check_value("o_dmem_addr", st[31:16], addr);
               check_value("o_dmem_wdata", st[15:0], m_regs[insn[11:9]]);
               model_mem[addr] = m_regs[insn[11:9]];
            end
         end
         lc4_pkg::OP_CONST: begin
            we  = 1'b1;
            res = {{7{insn[8]}}, insn[8:0]};
         end
         default: ;
      endcase
      if (insn[15:12] != lc4_pkg::OP_STR && store_q.size() != 0)
         abort_run("data memory was written but the retiring instruction is no store");
      check_value("o_wb_rf_we", o_wb_rf_we, we);
      check_value("o_wb_nzp_we", o_wb_nzp_we, we);   // every writer here also sets nzp
      if (we) begin
         check_value("o_wb_rf_wsel", o_wb_rf_wsel, insn[11:9]);
         check_value("o_wb_rf_wdata", o_wb_rf_wdata, res);
         check_value("o_wb_nzp", o_wb_nzp, cond_code(res));
         m_regs[insn[11:9]] = res;
         m_nzp = cond_code(res);
      end
      if (taken) begin
         pend_kind  = lc4_pkg::STALL_FLUSH;
         pend_count = 2;
      end else if (insn[15:12] == lc4_pkg::OP_LDR &&
                   load_hazard(prog_word(next_pc), insn[11:9])) begin
         pend_kind  = lc4_pkg::STALL_LOAD;
         pend_count = 1;
      end
      m_pc = next_pc;
      retired++;
   endtask

   task automatic check_record;
      if (!started && o_wb_stall != lc4_pkg::STALL_NONE) begin
         check_value("o_wb_stall", o_wb_stall, lc4_pkg::STALL_FLUSH);   // still filling
      end else begin
         check_value("o_wb_stall", o_wb_stall, (pend_count > 0) ? pend_kind : lc4_pkg::STALL_NONE);
         if (pend_count > 0) begin
            pend_count--;
         end else begin
            started = 1'b1;
            retire_step();
         end
      end
   endtask

   initial begin
      repeat (RESET_CYCLES + 4 * PROG_LEN + 50) @(posedge gwe);
      abort_run("watchdog expired because instructions stopped retiring before the program end");
   end

   initial begin
      void'($urandom(32'h5bed));
      i_reset    = 1'b1;
      m_pc       = lc4_pkg::RESET_PC;
      m_nzp      = lc4_pkg::NZP_ZERO;
      pend_kind  = lc4_pkg::STALL_NONE;
      pend_count = 0;
      retired    = 0;
      started    = 1'b0;
      for (int i = 0; i < 8; i++) m_regs[i] = '0;
      for (int a = 0; a < 65536; a++) dmem[a] = a[15:0];
      for (int i = 0; i < PROG_LEN; i++) imem[i] = random_insn();
      repeat (RESET_CYCLES) @(posedge gwe);
      i_reset <= 1'b0;
      @(negedge gwe);
      check_value("o_cur_pc", o_cur_pc, lc4_pkg::RESET_PC);
      check_value("o_dmem_we", o_dmem_we, 1'b0);
      while (m_pc < END_PC) begin
         check_record();
         if (o_dmem_we) store_q.push_back({o_dmem_addr, o_dmem_wdata});
         @(negedge gwe);
      end
      if (store_q.size() != 0) begin
         abort_run("data memory writes were left with no retiring store");
      end else begin
         $display("retired %0d instructions", retired);
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: lc4_pipeline.f
common/lc4_pkg.sv
decode/lc4_decoder.sv
decode/lc4_decode_stage.sv
execute/lc4_alu.sv
execute/lc4_execute_stage.sv
verilog/lc4_regfile.sv
result/lc4_result_stage.sv
verilog/lc4_pipeline.sv
sim/lc4_pipeline_chk.sv
sim/lc4_pipeline_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= lc4_pipeline_tb
FILELIST  ?= lc4_pipeline.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR FLAGS"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
